// File: design/scan_pkg.sv
/* Chain geometry and the encodings shared by the scan test block.
   Shift counts from 1 to long_len are supported. */

package scan_pkg;

  // Number of identical scan chain segments
  localparam int num_chains = 3;

  // Full chain length in flops
  localparam int long_len = 16;

  // Short chain is the first short_len flops of the same chain
  localparam int short_len = 4;

  // Wide enough to hold long_len
  localparam int count_width = 5;

  // Command opcodes on the request port
  typedef enum logic [1:0] {
    op_set_mode = 2'd0,
    op_shift    = 2'd1,
    op_capture  = 2'd2
  } scan_op_e;

  // Controller FSM states
  typedef enum logic [1:0] {
    st_idle    = 2'd0,
    st_shift   = 2'd1,
    st_capture = 2'd2,
    st_done    = 2'd3
  } ctrl_state_e;

endpackage

// File: design/test_mode_ctrl.sv
/* Command port FSM with four-phase req/ack. A shift with cmd_count of zero is
   acknowledged without shifting and produces no response. */

`timescale 1ns/10ps

module test_mode_ctrl (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 cmd_req,
  input  scan_pkg::scan_op_e                   cmd_op,
  input  logic [scan_pkg::long_len-1:0]        cmd_data,
  input  logic [scan_pkg::count_width-1:0]     cmd_count,
  input  logic                                 unload_busy,
  output logic                                 cmd_ack,
  output logic                                 shift_en,
  output logic                                 scan_in,
  output logic                                 capture_en,
  output logic                                 ctu_tst_pre_grst_l,
  output logic                                 ctu_tst_scanmode,
  output logic                                 ctu_tst_short_chain,
  output logic                                 ctu_tst_macrotest,
  output logic                                 ctu_tst_scan_disable,
  output logic                                 shift_done
);

  scan_pkg::ctrl_state_e                state;
  logic [scan_pkg::count_width-1:0]     rem_cnt;
  logic [scan_pkg::long_len-1:0]        shift_data;
  logic [3:0]                           mode_q;
  logic                                 last_shift;

  // Final shift cycle when one shift remains
  assign last_shift = (state == scan_pkg::st_shift) &&
                      (rem_cnt == (scan_pkg::count_width)'(1));

  assign shift_en   = (state == scan_pkg::st_shift);
  assign shift_done = last_shift;
  assign capture_en = (state == scan_pkg::st_capture);
  assign cmd_ack    = (state == scan_pkg::st_done);
  assign scan_in    = shift_data[0];

  // Mode register bit order: scanmode, short_chain, macrotest, scan_disable
  assign ctu_tst_scanmode     = mode_q[0];
  assign ctu_tst_short_chain  = mode_q[1];
  assign ctu_tst_macrotest    = mode_q[2];
  assign ctu_tst_scan_disable = mode_q[3];

  always_ff @(posedge clk) begin
    if (reset) begin
      state              <= scan_pkg::st_idle;
      rem_cnt            <= '0;
      mode_q             <= '0;
      ctu_tst_pre_grst_l <= 1'b0;
    end else begin
      ctu_tst_pre_grst_l <= 1'b1;
      case (state)
        scan_pkg::st_idle: begin
          if (cmd_req) begin
            case (cmd_op)
              scan_pkg::op_set_mode: begin
                mode_q <= cmd_data[3:0];
                state  <= scan_pkg::st_done;
              end
              scan_pkg::op_shift: begin
                // Hold off until the previous response has completed
                if (!unload_busy) begin
                  if (cmd_count == '0) begin
                    state <= scan_pkg::st_done;
                  end else begin
                    rem_cnt <= cmd_count;
                    state   <= scan_pkg::st_shift;
                  end
                end
              end
              scan_pkg::op_capture: state <= scan_pkg::st_capture;
              default:              state <= scan_pkg::st_done;
            endcase
          end
        end
        scan_pkg::st_shift: begin
          rem_cnt <= rem_cnt - (scan_pkg::count_width)'(1);
          if (last_shift) begin
            state <= scan_pkg::st_done;
          end
        end
        scan_pkg::st_capture: state <= scan_pkg::st_done;
        scan_pkg::st_done: begin
          // Ack stays up until the requester drops req
          if (!cmd_req) begin
            state <= scan_pkg::st_idle;
          end
        end
        default: state <= scan_pkg::st_idle;
      endcase
    end
  end

  // Pattern copy, bit k leaves on shift cycle k
  always_ff @(posedge clk) begin
    if (state == scan_pkg::st_idle) begin
      shift_data <= cmd_data;
    end else if (shift_en) begin
      shift_data <= shift_data >> 1;
    end
  end

endmodule

// File: design/scan_chain_segment.sv
/* One scan chain of long_len flops with a tap at short_len-1.
   Capture inverts every flop as a stand-in for the functional logic. */

`timescale 1ns/10ps

module scan_chain_segment (
  input  logic clk,
  input  logic reset,
  input  logic shift_en,
  input  logic scan_in,
  input  logic capture_en,
  output logic long_chain_so,
  output logic short_chain_so
);

  // Flop 0 is the scan input end
  logic [scan_pkg::long_len-1:0] chain;

  always_ff @(posedge clk) begin
    if (reset) begin
      chain <= '0;
    end else if (shift_en) begin
      chain <= {chain[scan_pkg::long_len-2:0], scan_in};
    end else if (capture_en) begin
      // Functional response of the core
      chain <= ~chain;
    end
  end

  // Short chain ends at flop short_len-1
  assign short_chain_so = chain[scan_pkg::short_len-1];
  assign long_chain_so  = chain[scan_pkg::long_len-1];

endmodule

// File: design/scan_chain_interface.sv
/* Combinational chain output select and global test control decode.
   No reset input; pre_grst_l stands in for reset to the decode. */

`timescale 1ns/10ps

module scan_chain_interface (
  input  logic ctu_tst_pre_grst_l,
  input  logic global_shift_enable,
  input  logic ctu_tst_scan_disable,
  input  logic ctu_tst_scanmode,
  input  logic ctu_tst_macrotest,
  input  logic ctu_tst_short_chain,
  input  logic long_chain_so_0,
  input  logic short_chain_so_0,
  input  logic long_chain_so_1,
  input  logic short_chain_so_1,
  input  logic long_chain_so_2,
  input  logic short_chain_so_2,
  output logic so_0,
  output logic so_1,
  output logic so_2,
  output logic se,
  output logic testmode_l,
  output logic mem_bypass,
  output logic sehold,
  output logic mux_drive_disable,
  output logic mem_write_disable
);

  logic short_chain_select;

  // scan_disable overrides the short chain only while shifting
  assign short_chain_select = ctu_tst_short_chain & ctu_tst_scanmode &
                              ~(ctu_tst_scan_disable & global_shift_enable);

  assign se         = global_shift_enable;
  assign testmode_l = ~ctu_tst_scanmode;
  assign mem_bypass = ctu_tst_scanmode & ~ctu_tst_macrotest;
  assign sehold     = ctu_tst_macrotest & ~se;

  assign so_0 = short_chain_select ? short_chain_so_0 : long_chain_so_0;
  assign so_1 = short_chain_select ? short_chain_so_1 : long_chain_so_1;
  assign so_2 = short_chain_select ? short_chain_so_2 : long_chain_so_2;

  assign mux_drive_disable = ~ctu_tst_pre_grst_l | short_chain_select | se;
  assign mem_write_disable = ~ctu_tst_pre_grst_l | se;

endmodule

// File: design/scan_unload.sv
/* Scan-out capture and response handshake. After a shift of n cycles the
   newest n bits sit at the top of each chain's field, first bit lowest. */

`timescale 1ns/10ps

module scan_unload (
  input  logic                                          clk,
  input  logic                                          reset,
  input  logic                                          se,
  input  logic                                          so_0,
  input  logic                                          so_1,
  input  logic                                          so_2,
  input  logic                                          shift_done,
  input  logic                                          rsp_ack,
  output logic                                          rsp_req,
  output logic [scan_pkg::num_chains*scan_pkg::long_len-1:0] rsp_data,
  output logic                                          unload_busy
);

  logic [scan_pkg::num_chains-1:0]                          so_vec;
  logic [scan_pkg::num_chains-1:0][scan_pkg::long_len-1:0]  cap_q;
  logic [scan_pkg::num_chains-1:0][scan_pkg::long_len-1:0]  cap_next;
  logic                                                     ack_wait;

  assign so_vec = {so_2, so_1, so_0};

  // New bit enters at the top, so the first bit out lands in bit 0
  always_comb begin
    cap_next = cap_q;
    if (se) begin
      for (int i = 0; i < scan_pkg::num_chains; i++) begin
        cap_next[i] = {so_vec[i], cap_q[i][scan_pkg::long_len-1:1]};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cap_q <= '0;
    end else begin
      cap_q <= cap_next;
    end
  end

  // Includes the bit sampled in the last shift cycle
  always_ff @(posedge clk) begin
    if (shift_done) begin
      rsp_data <= cap_next;
    end
  end

  // Four-phase response handshake
  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_req  <= 1'b0;
      ack_wait <= 1'b0;
    end else if (shift_done) begin
      rsp_req <= 1'b1;
    end else if (rsp_req && rsp_ack) begin
      rsp_req  <= 1'b0;
      ack_wait <= 1'b1;
    end else if (ack_wait && !rsp_ack) begin
      ack_wait <= 1'b0;
    end
  end

  // Busy from request until ack has dropped again
  assign unload_busy = rsp_req | ack_wait;

endmodule

// File: design/scan_test_top.sv
/* Scan test access block: command port, three scan segments, output decode
   and response port. Memory controls only leave through top-level ports. */

`timescale 1ns/10ps

module scan_test_top (
  input  logic                                               clk,
  input  logic                                               reset,
  input  logic                                               cmd_req,
  input  scan_pkg::scan_op_e                                 cmd_op,
  input  logic [scan_pkg::long_len-1:0]                      cmd_data,
  input  logic [scan_pkg::count_width-1:0]                   cmd_count,
  input  logic                                               rsp_ack,
  output logic                                               cmd_ack,
  output logic                                               rsp_req,
  output logic [scan_pkg::num_chains*scan_pkg::long_len-1:0] rsp_data,
  output logic                                               se,
  output logic                                               testmode_l,
  output logic                                               mem_bypass,
  output logic                                               sehold,
  output logic                                               mux_drive_disable,
  output logic                                               mem_write_disable
);

  logic                            shift_en;
  logic                            scan_in;
  logic                            capture_en;
  logic                            shift_done;
  logic                            unload_busy;
  logic                            ctu_tst_pre_grst_l;
  logic                            ctu_tst_scanmode;
  logic                            ctu_tst_short_chain;
  logic                            ctu_tst_macrotest;
  logic                            ctu_tst_scan_disable;
  logic [scan_pkg::num_chains-1:0] long_so;
  logic [scan_pkg::num_chains-1:0] short_so;
  logic                            so_0;
  logic                            so_1;
  logic                            so_2;

  test_mode_ctrl test_mode_ctrl_i (
    .clk                  (clk),
    .reset                (reset),
    .cmd_req              (cmd_req),
    .cmd_op               (cmd_op),
    .cmd_data             (cmd_data),
    .cmd_count            (cmd_count),
    .unload_busy          (unload_busy),
    .cmd_ack              (cmd_ack),
    .shift_en             (shift_en),
    .scan_in              (scan_in),
    .capture_en           (capture_en),
    .ctu_tst_pre_grst_l   (ctu_tst_pre_grst_l),
    .ctu_tst_scanmode     (ctu_tst_scanmode),
    .ctu_tst_short_chain  (ctu_tst_short_chain),
    .ctu_tst_macrotest    (ctu_tst_macrotest),
    .ctu_tst_scan_disable (ctu_tst_scan_disable),
    .shift_done           (shift_done)
  );

  // All segments see the same scan-in bit and controls
  for (genvar i = 0; i < scan_pkg::num_chains; i++) begin : g_seg
    scan_chain_segment scan_chain_segment_i (
      .clk            (clk),
      .reset          (reset),
      .shift_en       (shift_en),
      .scan_in        (scan_in),
      .capture_en     (capture_en),
      .long_chain_so  (long_so[i]),
      .short_chain_so (short_so[i])
    );
  end

  scan_chain_interface scan_chain_interface_i (
    .ctu_tst_pre_grst_l   (ctu_tst_pre_grst_l),
    .global_shift_enable  (shift_en),
    .ctu_tst_scan_disable (ctu_tst_scan_disable),
    .ctu_tst_scanmode     (ctu_tst_scanmode),
    .ctu_tst_macrotest    (ctu_tst_macrotest),
    .ctu_tst_short_chain  (ctu_tst_short_chain),
    .long_chain_so_0      (long_so[0]),
    .short_chain_so_0     (short_so[0]),
    .long_chain_so_1      (long_so[1]),
    .short_chain_so_1     (short_so[1]),
    .long_chain_so_2      (long_so[2]),
    .short_chain_so_2     (short_so[2]),
    .so_0                 (so_0),
    .so_1                 (so_1),
    .so_2                 (so_2),
    .se                   (se),
    .testmode_l           (testmode_l),
    .mem_bypass           (mem_bypass),
    .sehold               (sehold),
    .mux_drive_disable    (mux_drive_disable),
    .mem_write_disable    (mem_write_disable)
  );

  scan_unload scan_unload_i (
    .clk         (clk),
    .reset       (reset),
    .se          (se),
    .so_0        (so_0),
    .so_1        (so_1),
    .so_2        (so_2),
    .shift_done  (shift_done),
    .rsp_ack     (rsp_ack),
    .rsp_req     (rsp_req),
    .rsp_data    (rsp_data),
    .unload_busy (unload_busy)
  );

endmodule

// File: tb/scan_test_assert.sv
/* Concurrent checks for both handshakes, the decode rules and the shift length.
   Bound into scan_test_top, so it sees the internal control signals directly. */

`timescale 1ns/10ps

module scan_test_assert (
  input logic                                               clk,
  input logic                                               reset,
  input logic                                               cmd_req,
  input logic                                               cmd_ack,
  input scan_pkg::scan_op_e                                 cmd_op,
  input logic [scan_pkg::long_len-1:0]                      cmd_data,
  input logic [scan_pkg::count_width-1:0]                   cmd_count,
  input logic                                               rsp_req,
  input logic                                               rsp_ack,
  input logic [scan_pkg::num_chains*scan_pkg::long_len-1:0] rsp_data,
  input logic                                               shift_en,
  input logic                                               shift_done,
  input logic                                               unload_busy,
  input logic                                               ctu_tst_pre_grst_l,
  input logic                                               ctu_tst_scanmode,
  input logic                                               ctu_tst_short_chain,
  input logic                                               ctu_tst_macrotest,
  input logic                                               ctu_tst_scan_disable,
  input logic                                               se,
  input logic                                               testmode_l,
  input logic                                               mem_bypass,
  input logic                                               sehold,
  input logic                                               mux_drive_disable,
  input logic                                               mem_write_disable
);

  int   fail_count = 0;
  int   run_len;
  logic sel;

  assign sel = ctu_tst_short_chain & ctu_tst_scanmode & ~(ctu_tst_scan_disable & se);

  // Length of the current shift_en run
  always_ff @(posedge clk) begin
    if (reset || !shift_en) begin
      run_len <= 0;
    end else begin
      run_len <= run_len + 1;
    end
  end

  // Reset values
  assert property (@(posedge clk) reset && $past(reset) |-> mem_write_disable && mux_drive_disable)
    else begin fail_count++; $error("memory and mux disables low during reset"); end
  assert property (@(posedge clk) !reset && $past(reset) |->
                   !cmd_ack && !rsp_req && !se && testmode_l && !unload_busy)
    else begin fail_count++; $error("outputs not at reset values after reset"); end

  // Mode bits from the command port reach the mode outputs
  assert property (@(posedge clk) disable iff (reset)
                   $rose(cmd_ack) && cmd_op == scan_pkg::op_set_mode |->
                   testmode_l == !cmd_data[0] && mem_bypass == (cmd_data[0] && !cmd_data[2]) &&
                   sehold == cmd_data[2])
    else begin fail_count++; $error("mode outputs do not follow the op_set_mode bits"); end

  // Decode rules
  assert property (@(posedge clk) disable iff (reset)
                   testmode_l == !ctu_tst_scanmode &&
                   mem_bypass == (ctu_tst_scanmode && !ctu_tst_macrotest) &&
                   sehold == (ctu_tst_macrotest && !se) && se == shift_en)
    else begin fail_count++; $error("test mode decode does not follow the mode register"); end
  assert property (@(posedge clk) disable iff (reset)
                   mem_write_disable == (!ctu_tst_pre_grst_l || se) &&
                   mux_drive_disable == (!ctu_tst_pre_grst_l || sel || se))
    else begin fail_count++; $error("memory or mux disable decode is wrong"); end

  // Command handshake order
  assert property (@(posedge clk) disable iff (reset) $rose(cmd_ack) |-> cmd_req)
    else begin fail_count++; $error("cmd_ack rose without cmd_req"); end
  assert property (@(posedge clk) disable iff (reset) cmd_ack && cmd_req |=> cmd_ack)
    else begin fail_count++; $error("cmd_ack dropped while cmd_req still high"); end
  assert property (@(posedge clk) disable iff (reset) cmd_ack && !cmd_req |=> !cmd_ack)
    else begin fail_count++; $error("cmd_ack held after cmd_req fell"); end

  // Response handshake order and data stability
  assert property (@(posedge clk) disable iff (reset)
                   rsp_req && !rsp_ack |=> rsp_req && $stable(rsp_data))
    else begin fail_count++; $error("rsp_req or rsp_data changed before rsp_ack"); end
  assert property (@(posedge clk) disable iff (reset) rsp_req && rsp_ack |=> !rsp_req)
    else begin fail_count++; $error("rsp_req not released after rsp_ack"); end

  // Shifting
  assert property (@(posedge clk) disable iff (reset)
                   $rose(shift_en) |-> $past(!rsp_req && !rsp_ack))
    else begin fail_count++; $error("shift started while previous response pending"); end
  assert property (@(posedge clk) disable iff (reset) $fell(shift_en) |-> run_len == cmd_count)
    else begin fail_count++; $error("shift_en length differs from cmd_count"); end
  assert property (@(posedge clk) disable iff (reset)
                   shift_done == (shift_en && run_len + 1 == int'(cmd_count)))
    else begin fail_count++; $error("shift_done not in the last shift cycle"); end

endmodule

bind scan_test_top scan_test_assert scan_test_assert_i (
  .clk                  (clk),
  .reset                (reset),
  .cmd_req              (cmd_req),
  .cmd_ack              (cmd_ack),
  .cmd_op               (cmd_op),
  .cmd_data             (cmd_data),
  .cmd_count            (cmd_count),
  .rsp_req              (rsp_req),
  .rsp_ack              (rsp_ack),
  .rsp_data             (rsp_data),
  .shift_en             (shift_en),
  .shift_done           (shift_done),
  .unload_busy          (unload_busy),
  .ctu_tst_pre_grst_l   (ctu_tst_pre_grst_l),
  .ctu_tst_scanmode     (ctu_tst_scanmode),
  .ctu_tst_short_chain  (ctu_tst_short_chain),
  .ctu_tst_macrotest    (ctu_tst_macrotest),
  .ctu_tst_scan_disable (ctu_tst_scan_disable),
  .se                   (se),
  .testmode_l           (testmode_l),
  .mem_bypass           (mem_bypass),
  .sehold               (sehold),
  .mux_drive_disable    (mux_drive_disable),
  .mem_write_disable    (mem_write_disable)
);

// File: tb/scan_test_tb.sv
/* Testbench for scan_test_top with a reference chain model and random rsp_ack delay.
   Run length is bounded by a 4000 cycle watchdog. */

`timescale 1ns/10ps

module scan_test_tb;

  localparam int max_cycles = 4000;
  localparam int nch = scan_pkg::num_chains;
  localparam int llen = scan_pkg::long_len;

  logic                                 clk;
  logic                                 reset;
  logic                                 cmd_req;
  scan_pkg::scan_op_e                   cmd_op;
  logic [llen-1:0]                      cmd_data;
  logic [scan_pkg::count_width-1:0]     cmd_count;
  logic                                 rsp_ack;
  logic                                 cmd_ack;
  logic                                 rsp_req;
  logic [nch*llen-1:0]                  rsp_data;
  logic                                 se;
  logic                                 testmode_l;
  logic                                 mem_bypass;
  logic                                 sehold;
  logic                                 mux_drive_disable;
  logic                                 mem_write_disable;

  // Reference model state
  logic [llen-1:0]     model_chain [nch];
  logic [llen-1:0]     model_cap [nch];
  logic [3:0]          model_mode;
  logic [nch*llen-1:0] exp_q [$];
  int                  mismatch_count = 0;
  int                  cycle_count = 0;

  scan_test_top scan_test_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      $display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic send_cmd(input scan_pkg::scan_op_e op, input logic [llen-1:0] data,
                          input int count);
    @(posedge clk);
    #2;
    cmd_op    = op;
    cmd_data  = data;
    cmd_count = count[scan_pkg::count_width-1:0];
    cmd_req   = 1'b1;
    do @(negedge clk); while (!cmd_ack);
    @(posedge clk);
    #2;
    cmd_req = 1'b0;
    do @(negedge clk); while (cmd_ack);
  endtask

  task automatic set_mode(input logic [3:0] bits);
    model_mode = bits;
    send_cmd(scan_pkg::op_set_mode, {{(llen-4){1'b0}}, bits}, 0);
  endtask

  // Bit k of data enters on shift cycle k; unload samples before each shift
  task automatic shift_pattern(input logic [llen-1:0] data, input int count);
    logic               sel;
    logic               so;
    logic [nch*llen-1:0] expv;
    sel = model_mode[1] & model_mode[0] & ~model_mode[3];
    for (int k = 0; k < count; k++) begin
      for (int c = 0; c < nch; c++) begin
        so = sel ? model_chain[c][scan_pkg::short_len-1] : model_chain[c][llen-1];
        model_cap[c] = {so, model_cap[c][llen-1:1]};
        model_chain[c] = {model_chain[c][llen-2:0], data[k]};
      end
    end
    for (int c = 0; c < nch; c++) begin
      expv[c*llen +: llen] = model_cap[c];
    end
    exp_q.push_back(expv);
    send_cmd(scan_pkg::op_shift, data, count);
  endtask

  task automatic capture_once();
    for (int c = 0; c < nch; c++) begin
      model_chain[c] = ~model_chain[c];
    end
    send_cmd(scan_pkg::op_capture, '0, 0);
  endtask

  // Response side with random acknowledge delay
  initial begin
    logic [nch*llen-1:0] expv;
    int                  delay;
    rsp_ack = 1'b0;
    forever begin
      @(negedge clk);
      if (rsp_req && !rsp_ack) begin
        if (exp_q.size() == 0) begin
          mismatch_count++;
          $display("Response arrived with no shift pending at %0t", $time);
        end else begin
          expv = exp_q.pop_front();
          for (int c = 0; c < nch; c++) begin
            if (rsp_data[c*llen +: llen] !== expv[c*llen +: llen]) begin
              mismatch_count++;
              $display("MISMATCH at %0t: rsp_data chain %0d expected %h got %h", $time, c,
                       expv[c*llen +: llen], rsp_data[c*llen +: llen]);
            end
          end
        end
        delay = $urandom_range(0, 5);
        repeat (delay) @(posedge clk);
        @(posedge clk);
        #2;
        rsp_ack = 1'b1;
        do @(negedge clk); while (rsp_req);
        @(posedge clk);
        #2;
        rsp_ack = 1'b0;
      end
    end
  end

  initial begin
    logic [llen-1:0] pat;
    int              asrt_fails;
    void'($urandom(32093));
    reset     = 1'b1;
    cmd_req   = 1'b0;
    cmd_op    = scan_pkg::op_set_mode;
    cmd_data  = '0;
    cmd_count = '0;
    model_mode = '0;
    for (int c = 0; c < nch; c++) begin
      model_chain[c] = '0;
      model_cap[c]   = '0;
    end
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;

    // Long chain round trip
    set_mode(4'b0001);
    shift_pattern(16'($urandom), llen);
    shift_pattern(16'($urandom), llen);

    // Short chain, then scan_disable forcing long outputs while shifting
    set_mode(4'b0011);
    shift_pattern(16'($urandom), scan_pkg::short_len + 3);
    set_mode(4'b1011);
    shift_pattern(16'($urandom), scan_pkg::short_len + 5);

    // Capture between two shifts
    set_mode(4'b0001);
    pat = 16'($urandom);
    shift_pattern(pat, llen);
    capture_once();
    shift_pattern(16'($urandom), llen);

    // Random mix of modes, shifts and captures
    for (int i = 0; i < 30; i++) begin
      case ($urandom_range(0, 2))
        0: set_mode(4'($urandom));
        1: shift_pattern(16'($urandom), $urandom_range(1, llen));
        default: capture_once();
      endcase
    end

    do @(negedge clk); while (exp_q.size() != 0 || rsp_req || rsp_ack);
    repeat (5) @(posedge clk);

    asrt_fails = scan_test_top_i.scan_test_assert_i.fail_count;
    $display("Assertion failures: %0d, data mismatches: %0d", asrt_fails, mismatch_count);
    if (asrt_fails == 0 && mismatch_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: build.f
design/scan_pkg.sv
design/test_mode_ctrl.sv
design/scan_chain_segment.sv
design/scan_chain_interface.sv
design/scan_unload.sv
design/scan_test_top.sv
tb/scan_test_assert.sv
tb/scan_test_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator and run; pass only if the pass line shows up

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module scan_test_tb -Mdir obj_dir \
  && sim_out="$(./obj_dir/Vscan_test_tb +verilator+error+limit+1000)" \
  ; echo "$sim_out" \
  && echo "$sim_out" | grep -qx "Simulation passed" \
  && exit 0 \
  || exit 1
